// ==== build.f ====
axi_atop_pkg.sv
axi_lite_bus_if.sv
stream_register.sv
axi_atop_filter.sv
axi_ram_slave.sv
atop_filter_top.sv
tb_atop_filter.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_atop_filter \
  --Mdir obj_dir -o tb_atop_filter -f build.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_atop_filter > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0

// ==== tb_atop_filter.sv ====
`timescale 1ns/1ps

module tb_atop_filter import axi_atop_pkg::*; ();

  localparam int unsigned MemWords     = 64;
  localparam int unsigned NumRandomOps = 40;
  // Directed part plus a generous bound per random burst
  localparam int unsigned WatchdogCycles = 400 + NumRandomOps * 40;

  logic  clk_i = 1'b0;
  logic  rst_ni;
  logic  aw_valid_i, aw_ready_o;
  id_t   aw_id_i;
  addr_t aw_addr_i;
  len_t  aw_len_i;
  atop_t aw_atop_i;
  logic  w_valid_i, w_ready_o, w_last_i;
  data_t w_data_i;
  strb_t w_strb_i;
  logic  b_valid_o, b_ready_i;
  id_t   b_id_o;
  resp_t b_resp_o;
  logic  ar_valid_i, ar_ready_o;
  id_t   ar_id_i;
  addr_t ar_addr_i;
  len_t  ar_len_i;
  logic  r_valid_o, r_ready_i, r_last_o;
  id_t   r_id_o;
  data_t r_data_o;
  resp_t r_resp_o;

  // Reference copy of the RAM, only ordinary writes land here
  data_t ref_mem [MemWords];
  // Expected responses in arrival order
  id_t   exp_b_id [256];
  resp_t exp_b_resp [256];
  id_t   exp_r_id [1024];
  resp_t exp_r_resp [1024];
  data_t exp_r_data [1024];
  logic  exp_r_chk [1024];
  logic  exp_r_last [1024];
  int    b_exp_cnt = 0;
  int    r_exp_cnt = 0;
  int    b_idx = 0;
  int    r_idx = 0;
  int    fail_count = 0;
  int    tests_run = 0;
  int    seed = 91;

  always #50 clk_i = ~clk_i;

  atop_filter_top #(
    .MaxWriteTxns (4),
    .MemWords     (MemWords)
  ) dut (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .aw_valid_i (aw_valid_i), .aw_ready_o (aw_ready_o), .aw_id_i (aw_id_i),
    .aw_addr_i (aw_addr_i), .aw_len_i (aw_len_i), .aw_atop_i (aw_atop_i),
    .w_valid_i (w_valid_i), .w_ready_o (w_ready_o), .w_data_i (w_data_i),
    .w_strb_i (w_strb_i), .w_last_i (w_last_i),
    .b_valid_o (b_valid_o), .b_ready_i (b_ready_i), .b_id_o (b_id_o), .b_resp_o (b_resp_o),
    .ar_valid_i (ar_valid_i), .ar_ready_o (ar_ready_o), .ar_id_i (ar_id_i),
    .ar_addr_i (ar_addr_i), .ar_len_i (ar_len_i),
    .r_valid_o (r_valid_o), .r_ready_i (r_ready_i), .r_id_o (r_id_o),
    .r_data_o (r_data_o), .r_resp_o (r_resp_o), .r_last_o (r_last_o)
  );

  task automatic report_fail(input string msg);
    fail_count++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  // Response pointers advance on each completed handshake
  always @(posedge clk_i) begin
    if (b_valid_o && b_ready_i) begin
      b_idx <= b_idx + 1;
    end
    if (r_valid_o && r_ready_i) begin
      r_idx <= r_idx + 1;
    end
  end

  a_b_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (b_valid_o && b_ready_i) |-> (b_idx < b_exp_cnt) && (b_id_o == exp_b_id[b_idx])
      && (b_resp_o == exp_b_resp[b_idx])
  ) else report_fail("B response is unexpected or has the wrong ID or resp");

  a_r_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && r_ready_i) |-> (r_idx < r_exp_cnt) && (r_id_o == exp_r_id[r_idx])
      && (r_resp_o == exp_r_resp[r_idx]) && (r_last_o == exp_r_last[r_idx])
  ) else report_fail("R beat is unexpected or has the wrong ID, resp or last");

  // Injected beats carry no meaningful data
  a_r_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && r_ready_i && exp_r_chk[r_idx]) |-> (r_data_o == exp_r_data[r_idx])
  ) else report_fail("R data differs from the reference memory");

  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (b_valid_o && !b_ready_i) |=> b_valid_o && $stable(b_id_o) && $stable(b_resp_o)
  ) else report_fail("B valid or payload changed under back-pressure");

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && !r_ready_i) |=> r_valid_o && $stable(r_id_o) && $stable(r_data_o)
      && $stable(r_resp_o) && $stable(r_last_o)
  ) else report_fail("R valid or payload changed under back-pressure");

  task automatic add_b_expectation(input id_t id, input resp_t resp);
    exp_b_id[b_exp_cnt] = id;
    exp_b_resp[b_exp_cnt] = resp;
    b_exp_cnt++;
  endtask

  task automatic queue_r_beat(input id_t id, input resp_t resp, input data_t data,
                              input logic chk, input logic last);
    exp_r_id[r_exp_cnt] = id;
    exp_r_resp[r_exp_cnt] = resp;
    exp_r_data[r_exp_cnt] = data;
    exp_r_chk[r_exp_cnt] = chk;
    exp_r_last[r_exp_cnt] = last;
    r_exp_cnt++;
  endtask

  // Called at a falling edge, returns at a falling edge
  task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                             input atop_t atop, input logic rnd_strb, input int stall);
    data_t       wdata[$];
    strb_t       wstrb[$];
    logic [31:0] rnd;
    int          idx;
    logic        atomic;
    atomic = atop[5:4] != AtopNone;
    for (int k = 0; k <= int'(len); k++) begin
      rnd = $random(seed);
      wdata.push_back(rnd);
      rnd = $random(seed);
      wstrb.push_back(rnd_strb ? rnd[3:0] : 4'hF);
      idx = (int'(addr[7:2]) + k) % MemWords;
      for (int b = 0; b < 4; b++) begin
        if (!atomic && wstrb[k][b]) begin
          ref_mem[idx][8*b +: 8] = wdata[k][8*b +: 8];
        end
      end
    end
    // Atomics end in SLVERR, all but stores also get len+1 R beats
    add_b_expectation(id, atomic ? RespSlvErr : RespOkay);
    if (atomic && atop[5:4] != AtopAtomicStore) begin
      for (int k = 0; k <= int'(len); k++) begin
        queue_r_beat(id, RespSlvErr, '0, 1'b0, k == int'(len));
      end
    end
    if (stall > 0) begin
      b_ready_i = 1'b0;
      r_ready_i = 1'b0;
    end
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = addr;
    aw_len_i   = len;
    aw_atop_i  = atop;
    #1;
    while (!aw_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      w_valid_i = 1'b1;
      w_data_i  = wdata[k];
      w_strb_i  = wstrb[k];
      w_last_i  = k == int'(len);
      #1;
      while (!w_ready_o) begin
        @(negedge clk_i);
        #1;
      end
      @(negedge clk_i);
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    repeat (stall) @(negedge clk_i);
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    wait (b_idx == b_exp_cnt && r_idx == r_exp_cnt);
    // Quiet gap, any stray response trips the match checks
    repeat (2) @(negedge clk_i);
  endtask

  task automatic read_burst(input id_t id, input addr_t addr, input len_t len,
                            input int stall);
    int idx;
    for (int k = 0; k <= int'(len); k++) begin
      idx = (int'(addr[7:2]) + k) % MemWords;
      queue_r_beat(id, RespOkay, ref_mem[idx], 1'b1, k == int'(len));
    end
    if (stall > 0) begin
      r_ready_i = 1'b0;
    end
    ar_valid_i = 1'b1;
    ar_id_i    = id;
    ar_addr_i  = addr;
    ar_len_i   = len;
    #1;
    while (!ar_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    repeat (stall) @(negedge clk_i);
    r_ready_i = 1'b1;
    wait (r_idx == r_exp_cnt);
    repeat (2) @(negedge clk_i);
  endtask

  task automatic close_test(input int num, input string name, input int start_errs);
    tests_run++;
    $display("Test %0d %s: %0d failed checks", num, name, fail_count - start_errs);
  endtask

  initial begin
    int          start_errs;
    logic [31:0] rnd;
    logic [1:0]  cls;
    rst_ni     = 1'b0;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    aw_atop_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b1;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    r_ready_i  = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    // Whole RAM gets known contents first
    for (int k = 0; k < 4; k++) begin
      write_burst(4'd0, addr_t'(k * 64), 8'd15, '0, 1'b0, 0);
    end

    start_errs = fail_count;
    write_burst(4'd3, 8'h40, 8'd3, '0, 1'b0, 0);
    read_burst(4'd7, 8'h40, 8'd3, 0);
    close_test(1, "ordinary write and read back", start_errs);

    start_errs = fail_count;
    write_burst(4'd5, 8'h40, 8'd3, 6'b10_0000, 1'b0, 0);
    read_burst(4'd6, 8'h40, 8'd3, 0);
    close_test(2, "atomic load rejected", start_errs);

    start_errs = fail_count;
    write_burst(4'd9, 8'h80, 8'd1, 6'b01_0000, 1'b0, 0);
    read_burst(4'd2, 8'h80, 8'd1, 0);
    close_test(3, "atomic store rejected", start_errs);

    // Forwarded and injected responses under stalled readies
    start_errs = fail_count;
    write_burst(4'd1, 8'hC0, 8'd2, '0, 1'b1, 5);
    read_burst(4'd1, 8'hC0, 8'd2, 5);
    write_burst(4'd12, 8'h10, 8'd3, 6'b11_0001, 1'b0, 5);
    read_burst(4'd4, 8'h10, 8'd3, 3);
    close_test(4, "back-pressure", start_errs);

    start_errs = fail_count;
    for (int n = 0; n < NumRandomOps; n++) begin
      rnd = $random(seed);
      cls = (rnd[21:20] == 2'd0) ? 2'd2 : rnd[21:20];
      case (rnd[17:16])
        2'd0: write_burst(rnd[3:0], {rnd[11:6], 2'b00}, {5'd0, rnd[14:12]}, '0, 1'b0, 0);
        2'd1: read_burst(rnd[3:0], {rnd[11:6], 2'b00}, {5'd0, rnd[14:12]}, 0);
        2'd2: write_burst(rnd[3:0], {rnd[11:6], 2'b00}, {5'd0, rnd[14:12]}, '0, 1'b1, 0);
        default: write_burst(rnd[3:0], {rnd[11:6], 2'b00}, {5'd0, rnd[14:12]},
                             {cls, 3'b000, rnd[24]}, 1'b0, 0);
      endcase
    end
    close_test(5, "random mix", start_errs);

    $display("Tests run: %0d, failed checks: %0d", tests_run, fail_count);
    if (fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Ends a hung run
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WatchdogCycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== atop_filter_top.sv ====
`timescale 1ns/1ps

module atop_filter_top import axi_atop_pkg::*; #(
  parameter int unsigned MaxWriteTxns = 4,
  parameter int unsigned MemWords     = 64
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  // AW
  input  logic  aw_valid_i,
  output logic  aw_ready_o,
  input  id_t   aw_id_i,
  input  addr_t aw_addr_i,
  input  len_t  aw_len_i,
  input  atop_t aw_atop_i,
  // W
  input  logic  w_valid_i,
  output logic  w_ready_o,
  input  data_t w_data_i,
  input  strb_t w_strb_i,
  input  logic  w_last_i,
  // B
  output logic  b_valid_o,
  input  logic  b_ready_i,
  output id_t   b_id_o,
  output resp_t b_resp_o,
  // AR
  input  logic  ar_valid_i,
  output logic  ar_ready_o,
  input  id_t   ar_id_i,
  input  addr_t ar_addr_i,
  input  len_t  ar_len_i,
  // R
  output logic  r_valid_o,
  input  logic  r_ready_i,
  output id_t   r_id_o,
  output data_t r_data_o,
  output resp_t r_resp_o,
  output logic  r_last_o
);

  // Upstream bus driven from the ports
  axi_lite_bus_if up_bus ();
  // Filtered bus into the memory
  axi_lite_bus_if dn_bus ();

  assign up_bus.aw_valid = aw_valid_i;
  assign up_bus.aw_id    = aw_id_i;
  assign up_bus.aw_addr  = aw_addr_i;
  assign up_bus.aw_len   = aw_len_i;
  assign up_bus.aw_atop  = aw_atop_i;
  assign up_bus.w_valid  = w_valid_i;
  assign up_bus.w_data   = w_data_i;
  assign up_bus.w_strb   = w_strb_i;
  assign up_bus.w_last   = w_last_i;
  assign up_bus.b_ready  = b_ready_i;
  assign up_bus.ar_valid = ar_valid_i;
  assign up_bus.ar_id    = ar_id_i;
  assign up_bus.ar_addr  = ar_addr_i;
  assign up_bus.ar_len   = ar_len_i;
  assign up_bus.r_ready  = r_ready_i;

  assign aw_ready_o = up_bus.aw_ready;
  assign w_ready_o  = up_bus.w_ready;
  assign b_valid_o  = up_bus.b_valid;
  assign b_id_o     = up_bus.b_id;
  assign b_resp_o   = up_bus.b_resp;
  assign ar_ready_o = up_bus.ar_ready;
  assign r_valid_o  = up_bus.r_valid;
  assign r_id_o     = up_bus.r_id;
  assign r_data_o   = up_bus.r_data;
  assign r_resp_o   = up_bus.r_resp;
  assign r_last_o   = up_bus.r_last;

  axi_atop_filter #(
    .MaxWriteTxns (MaxWriteTxns)
  ) u_filter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .slv    (up_bus.slv),
    .mst    (dn_bus.mst)
  );

  axi_ram_slave #(
    .MemWords (MemWords)
  ) u_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (dn_bus.slv)
  );

endmodule

// ==== axi_ram_slave.sv ====
`timescale 1ns/1ps

module axi_ram_slave import axi_atop_pkg::*; #(
  parameter int unsigned MemWords = 64
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  axi_lite_bus_if.slv  bus
);

  localparam int unsigned IdxWidth = $clog2(MemWords);
  typedef logic [IdxWidth-1:0] idx_t;

  typedef enum logic [1:0] {WrIdle, WrData, WrResp} wr_state_e;
  typedef enum logic {RdIdle, RdData} rd_state_e;

  wr_state_e wr_state_q;
  rd_state_e rd_state_q;
  data_t     mem_q [MemWords];
  logic      aw_ready_q, ar_ready_q;
  id_t       wr_id_q, rd_id_q;
  idx_t      wr_idx_q, rd_idx_q;
  len_t      rd_cnt_q;
  data_t     rd_data_q;
  logic      aw_hs, w_hs, b_hs, ar_hs, r_hs;

  assign aw_hs = bus.aw_valid && bus.aw_ready;
  assign w_hs  = bus.w_valid && bus.w_ready;
  assign b_hs  = bus.b_valid && bus.b_ready;
  assign ar_hs = bus.ar_valid && bus.ar_ready;
  assign r_hs  = bus.r_valid && bus.r_ready;

  // Address readies are registered and rise one cycle after valid
  assign bus.aw_ready = aw_ready_q;
  assign bus.ar_ready = ar_ready_q;
  assign bus.w_ready  = wr_state_q == WrData;
  assign bus.b_valid  = wr_state_q == WrResp;
  assign bus.b_id     = wr_id_q;
  assign bus.b_resp   = RespOkay;
  assign bus.r_valid  = rd_state_q == RdData;
  assign bus.r_id     = rd_id_q;
  assign bus.r_data   = rd_data_q;
  assign bus.r_resp   = RespOkay;
  assign bus.r_last   = rd_cnt_q == '0;

  // Write engine
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_state_q <= WrIdle;
      aw_ready_q <= 1'b0;
    end else begin
      unique case (wr_state_q)
        WrIdle: begin
          aw_ready_q <= bus.aw_valid && !aw_hs;
          if (aw_hs) begin
            wr_state_q <= WrData;
          end
        end
        WrData: begin
          if (w_hs && bus.w_last) begin
            wr_state_q <= WrResp;
          end
        end
        WrResp: begin
          if (b_hs) begin
            wr_state_q <= WrIdle;
          end
        end
        default: wr_state_q <= WrIdle;
      endcase
    end
  end

  // Burst address and ID, word index wraps at the memory size
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      wr_id_q  <= bus.aw_id;
      wr_idx_q <= idx_t'(bus.aw_addr >> 2);
    end else if (w_hs) begin
      wr_idx_q <= wr_idx_q + idx_t'(1);
    end
  end

  // Byte lanes written under strobe
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < DataWidth / 8; i++) begin
      if (w_hs && bus.w_strb[i]) begin
        mem_q[wr_idx_q][8*i +: 8] <= bus.w_data[8*i +: 8];
      end
    end
  end

  // Read engine
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_state_q <= RdIdle;
      ar_ready_q <= 1'b0;
    end else begin
      unique case (rd_state_q)
        RdIdle: begin
          ar_ready_q <= bus.ar_valid && !ar_hs;
          if (ar_hs) begin
            rd_state_q <= RdData;
          end
        end
        RdData: begin
          if (r_hs && bus.r_last) begin
            rd_state_q <= RdIdle;
          end
        end
        default: rd_state_q <= RdIdle;
      endcase
    end
  end

  // Data register always holds the word of the current beat
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rd_id_q   <= bus.ar_id;
      rd_cnt_q  <= bus.ar_len;
      rd_idx_q  <= idx_t'(bus.ar_addr >> 2) + idx_t'(1);
      rd_data_q <= mem_q[idx_t'(bus.ar_addr >> 2)];
    end else if (r_hs && !bus.r_last) begin
      rd_cnt_q  <= rd_cnt_q - len_t'(1);
      rd_idx_q  <= rd_idx_q + idx_t'(1);
      rd_data_q <= mem_q[rd_idx_q];
    end
  end

  // Upstream filtering keeps atomics away from this memory
  a_no_atop: assert property (
    @(posedge clk_i) disable iff (!rst_ni) bus.aw_valid |-> bus.aw_atop == '0
  ) else $error("atomic AW reached the memory");

endmodule

// ==== axi_atop_filter.sv ====
`timescale 1ns/1ps

module axi_atop_filter import axi_atop_pkg::*; #(
  parameter int unsigned MaxWriteTxns = 4
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  axi_lite_bus_if.slv    slv,
  axi_lite_bus_if.mst    mst
);

  typedef logic [$clog2(MaxWriteTxns+1)-1:0] cnt_t;
  typedef enum logic [2:0] {WFeedthrough, BlockAw, AbsorbW, InjectB, WaitR} w_state_e;
  typedef enum logic {RFeedthrough, InjectR} r_state_e;

  w_state_e w_state_d, w_state_q;
  r_state_e r_state_d, r_state_q;
  cnt_t     w_cnt_d, w_cnt_q;
  id_t      id_d, id_q;
  len_t     r_beats_d, r_beats_q;
  logic     aw_is_atop, aw_is_store;
  logic     cmd_push_valid, cmd_push_ready;
  logic     cmd_pop_valid, cmd_pop_ready;
  len_t     cmd_pop_len;
  // High while the upstream B or R channel shows the downstream response
  logic     b_fwd, r_fwd;
  // Forwarded response still waiting upstream, so no injection may replace it
  logic     b_fwd_pend_q, r_fwd_pend_q;
  logic     r_inj_last;

  assign aw_is_atop  = slv.aw_atop[5:4] != AtopNone;
  assign aw_is_store = slv.aw_atop[5:4] == AtopAtomicStore;

  // Write side FSM
  always_comb begin
    mst.aw_valid   = 1'b0;
    slv.aw_ready   = 1'b0;
    mst.w_valid    = 1'b0;
    slv.w_ready    = 1'b0;
    b_fwd          = 1'b1;
    id_d           = id_q;
    cmd_push_valid = 1'b0;
    w_state_d      = w_state_q;
    unique case (w_state_q)
      WFeedthrough: begin
        // W only follows a forwarded AW
        if (w_cnt_q != '0) begin
          mst.w_valid = slv.w_valid;
          slv.w_ready = mst.w_ready;
        end
        if (slv.aw_valid && aw_is_atop) begin
          if (w_cnt_q != '0) begin
            // Atomic AW waits until the forwarded bursts are done
            w_state_d = BlockAw;
          end else begin
            // Atomic AW is swallowed here
            slv.aw_ready = cmd_push_ready;
            if (cmd_push_ready) begin
              id_d = slv.aw_id;
              // Atomic store gets no R response
              cmd_push_valid = !aw_is_store;
              // Nothing outstanding, so the W beats belong to this AW
              slv.w_ready = 1'b1;
              w_state_d   = (slv.w_valid && slv.w_last) ? InjectB : AbsorbW;
            end
          end
        end else if (w_cnt_q < MaxWriteTxns) begin
          mst.aw_valid = slv.aw_valid;
          slv.aw_ready = mst.aw_ready;
        end
      end
      BlockAw: begin
        // Drain the forwarded bursts first
        if (w_cnt_q != '0) begin
          mst.w_valid = slv.w_valid;
          slv.w_ready = mst.w_ready;
        end else begin
          // Held atomic AW is taken once back in feedthrough
          w_state_d = WFeedthrough;
        end
      end
      AbsorbW: begin
        slv.w_ready = 1'b1;
        if (slv.w_valid && slv.w_last) begin
          w_state_d = InjectB;
        end
      end
      InjectB: begin
        // Let a pending forwarded B finish before taking over the channel
        if (!b_fwd_pend_q) begin
          b_fwd = 1'b0;
          if (slv.b_ready) begin
            if (cmd_pop_valid && !cmd_pop_ready) begin
              w_state_d = WaitR;
            end else begin
              w_state_d = WFeedthrough;
            end
          end
        end
      end
      WaitR: begin
        // Stored ID is still in use by the R injection
        if (!cmd_pop_valid) begin
          w_state_d = WFeedthrough;
        end
      end
      default: w_state_d = WFeedthrough;
    endcase
  end

  // Payload passes through, atop is cleared downstream
  assign mst.aw_id   = slv.aw_id;
  assign mst.aw_addr = slv.aw_addr;
  assign mst.aw_len  = slv.aw_len;
  assign mst.aw_atop = '0;
  assign mst.w_data  = slv.w_data;
  assign mst.w_strb  = slv.w_strb;
  assign mst.w_last  = slv.w_last;

  // B mux, injected response carries the stored ID
  assign mst.b_ready = b_fwd ? slv.b_ready : 1'b0;
  assign slv.b_valid = b_fwd ? mst.b_valid : 1'b1;
  assign slv.b_id    = b_fwd ? mst.b_id : id_q;
  assign slv.b_resp  = b_fwd ? mst.b_resp : RespSlvErr;

  // Read side FSM
  always_comb begin
    r_fwd         = 1'b1;
    r_inj_last    = 1'b0;
    cmd_pop_ready = 1'b0;
    r_beats_d     = r_beats_q;
    r_state_d     = r_state_q;
    unique case (r_state_q)
      RFeedthrough: begin
        // First injected beat goes out straight from the register
        if (cmd_pop_valid && !r_fwd_pend_q) begin
          r_fwd      = 1'b0;
          r_inj_last = cmd_pop_len == '0;
          if (slv.r_ready && r_inj_last) begin
            cmd_pop_ready = 1'b1;
          end else begin
            r_beats_d = slv.r_ready ? cmd_pop_len - len_t'(1) : cmd_pop_len;
            r_state_d = InjectR;
          end
        end
      end
      InjectR: begin
        r_fwd      = 1'b0;
        r_inj_last = r_beats_q == '0;
        if (slv.r_ready) begin
          if (r_inj_last) begin
            cmd_pop_ready = 1'b1;
            r_state_d     = RFeedthrough;
          end else begin
            r_beats_d = r_beats_q - len_t'(1);
          end
        end
      end
      default: r_state_d = RFeedthrough;
    endcase
  end

  // R mux, data of an injected beat is zero
  assign mst.r_ready = r_fwd ? slv.r_ready : 1'b0;
  assign slv.r_valid = r_fwd ? mst.r_valid : 1'b1;
  assign slv.r_id    = r_fwd ? mst.r_id : id_q;
  assign slv.r_data  = r_fwd ? mst.r_data : '0;
  assign slv.r_resp  = r_fwd ? mst.r_resp : RespSlvErr;
  assign slv.r_last  = r_fwd ? mst.r_last : r_inj_last;

  // AR is never touched
  assign mst.ar_valid = slv.ar_valid;
  assign mst.ar_id    = slv.ar_id;
  assign mst.ar_addr  = slv.ar_addr;
  assign mst.ar_len   = slv.ar_len;
  assign slv.ar_ready = mst.ar_ready;

  // Downstream write bursts whose last W has not yet passed
  always_comb begin
    w_cnt_d = w_cnt_q;
    if (mst.aw_valid && mst.aw_ready) begin
      w_cnt_d = w_cnt_d + cnt_t'(1);
    end
    if (mst.w_valid && mst.w_ready && mst.w_last) begin
      w_cnt_d = w_cnt_d - cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q    <= WFeedthrough;
      r_state_q    <= RFeedthrough;
      w_cnt_q      <= '0;
      id_q         <= '0;
      r_beats_q    <= '0;
      b_fwd_pend_q <= 1'b0;
      r_fwd_pend_q <= 1'b0;
    end else begin
      w_state_q    <= w_state_d;
      r_state_q    <= r_state_d;
      w_cnt_q      <= w_cnt_d;
      id_q         <= id_d;
      r_beats_q    <= r_beats_d;
      b_fwd_pend_q <= b_fwd && slv.b_valid && !slv.b_ready;
      r_fwd_pend_q <= r_fwd && slv.r_valid && !slv.r_ready;
    end
  end

  // Pending R injection, payload is the beat count minus one
  stream_register #(
    .T (len_t)
  ) r_resp_cmd (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (cmd_push_valid),
    .ready_o (cmd_push_ready),
    .data_i  (slv.aw_len),
    .valid_o (cmd_pop_valid),
    .ready_i (cmd_pop_ready),
    .data_o  (cmd_pop_len)
  );

  // Whatever reaches the memory came from a non-atomic AW
  a_no_atop_downstream: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mst.aw_valid |-> slv.aw_atop[5:4] == AtopNone
  ) else $error("atomic AW leaked downstream");

  a_cnt_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni) w_cnt_q <= MaxWriteTxns
  ) else $error("outstanding write count above limit");

endmodule

// ==== stream_register.sv ====
`timescale 1ns/1ps

module stream_register import axi_atop_pkg::*; #(
  parameter type T = len_t
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Push side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // Pop side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic valid_q;
  T     data_q;

  // Accepts a new entry only while empty
  assign ready_o = !valid_q;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
    end else if (valid_q && ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload is loaded on a push only
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  // The producer must wait for the entry to drain before the next push
  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni) valid_i |-> !valid_q
  ) else $error("push into full stream register");

endmodule

// ==== axi_lite_bus_if.sv ====
`timescale 1ns/1ps

interface axi_lite_bus_if import axi_atop_pkg::*; ();

  // AW channel
  logic  aw_valid;
  logic  aw_ready;
  id_t   aw_id;
  addr_t aw_addr;
  len_t  aw_len;
  atop_t aw_atop;

  // W channel
  logic  w_valid;
  logic  w_ready;
  data_t w_data;
  strb_t w_strb;
  logic  w_last;

  // B channel
  logic  b_valid;
  logic  b_ready;
  id_t   b_id;
  resp_t b_resp;

  // AR channel
  logic  ar_valid;
  logic  ar_ready;
  id_t   ar_id;
  addr_t ar_addr;
  len_t  ar_len;

  // R channel
  logic  r_valid;
  logic  r_ready;
  id_t   r_id;
  data_t r_data;
  resp_t r_resp;
  logic  r_last;

  // Requesting side
  modport mst (
    output aw_valid, aw_id, aw_addr, aw_len, aw_atop,
    output w_valid, w_data, w_strb, w_last,
    output b_ready,
    output ar_valid, ar_id, ar_addr, ar_len,
    output r_ready,
    input  aw_ready, w_ready, b_valid, b_id, b_resp,
    input  ar_ready, r_valid, r_id, r_data, r_resp, r_last
  );

  // Responding side
  modport slv (
    input  aw_valid, aw_id, aw_addr, aw_len, aw_atop,
    input  w_valid, w_data, w_strb, w_last,
    input  b_ready,
    input  ar_valid, ar_id, ar_addr, ar_len,
    input  r_ready,
    output aw_ready, w_ready, b_valid, b_id, b_resp,
    output ar_ready, r_valid, r_id, r_data, r_resp, r_last
  );

endinterface

// ==== axi_atop_pkg.sv ====
package axi_atop_pkg;

  // Bus widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 8;
  localparam int unsigned DataWidth = 32;

  // Vector types for the channel fields
  typedef logic [IdWidth-1:0]     id_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [DataWidth/8-1:0] strb_t;
  // Burst length minus one
  typedef logic [7:0]             len_t;
  typedef logic [5:0]             atop_t;
  typedef logic [1:0]             resp_t;

  // Response codes
  localparam resp_t RespOkay   = 2'd0;
  localparam resp_t RespSlvErr = 2'd2;

  // Atop class in bits 5:4 of the atop field
  localparam logic [1:0] AtopNone        = 2'd0;
  localparam logic [1:0] AtopAtomicStore = 2'd1;

endpackage
